// File: verilog/rv_fetch_config.svh
`ifndef RV_FETCH_CONFIG_SVH
`define RV_FETCH_CONFIG_SVH

// First fetch address after reset
`define RV_RESET_ADDR       32'h0000_0040

// Prefetch queue entries, power of two
`define RV_FETCH_BUF_DEPTH  4

// 1'b1 lets the predecoder steer the PC, 1'b0 fetches straight through
`define RV_FETCH_PREDICT    1'b1

`endif

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;

    // Major opcode field, instr[6:2]
    typedef enum logic [4:0]
    {
        OPC_LOAD    = 5'b00000,
        OPC_OP_IMM  = 5'b00100,
        OPC_AUIPC   = 5'b00101,
        OPC_STORE   = 5'b01000,
        OPC_OP      = 5'b01100,
        OPC_LUI     = 5'b01101,
        OPC_BRANCH  = 5'b11000,
        OPC_JALR    = 5'b11001,
        OPC_JAL     = 5'b11011,
        OPC_SYSTEM  = 5'b11100
    } rv_opcode_t;

    // instr[1:0] of every 32-bit instruction
    localparam logic [1:0] RV_OPC_LEN32 = 2'b11;

endpackage

`default_nettype wire

// File: verilog/rv_fetch_pkg.sv
`default_nettype none

`include "rv_fetch_config.svh"

package rv_fetch_pkg;

    typedef enum logic [1:0]
    {
        FS_IDLE     = 2'b00,    // No request on the bus
        FS_REQ      = 2'b01,    // Request out, word wanted
        FS_DRAIN    = 2'b10     // Request out, word to be dropped
    } fetch_state_t;

    localparam int BUF_IDX_W = $clog2(`RV_FETCH_BUF_DEPTH);

    typedef logic [BUF_IDX_W-1:0] buf_idx_t;

endpackage

`default_nettype wire

// File: verilog/rv_fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rv_fetch_ctrl
(
    input   wire                        i_clk,
    input   wire                        i_reset_n,
    input   wire                        i_pc_select,
    input   wire                        i_ack,
    input   wire                        i_has_room,
    input   wire rv_isa_pkg::word_t     i_fetch_pc,
    output  logic                       o_cyc,
    output  logic                       o_wr,
    output  rv_isa_pkg::word_t          o_addr
);

    import rv_fetch_pkg::*;

    fetch_state_t   state;
    fetch_state_t   state_next;
    logic           issue;

    // Word goes to the queue only in FS_REQ and without a redirect
    assign  o_wr = (state == FS_REQ) && i_ack && !i_pc_select;
    assign  o_cyc = (state != FS_IDLE);

    always_comb
    begin
        state_next = state;
        issue = 1'b0;
        case (state)
            FS_IDLE:
            begin
                if (i_has_room)
                begin
                    state_next = FS_REQ;
                    issue = 1'b1;
                end
            end
            FS_REQ, FS_DRAIN:
            begin
                if (i_ack)
                begin
                    // Back-to-back request when the queue still has a slot
                    state_next = i_has_room ? FS_REQ : FS_IDLE;
                    issue = i_has_room;
                end
                else if (i_pc_select)
                    state_next = FS_DRAIN;  // Stale word still to come
            end
            default:
                state_next = FS_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= FS_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (issue)
            o_addr <= i_fetch_pc;
    end

    // Memory sees one address per request
    a_addr_stable: assert property
    (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_cyc && !i_ack |=> $stable(o_addr)
    );

    // Word asked for before a redirect never reaches the queue
    a_no_wr_in_drain: assert property
    (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_cyc && !i_ack && i_pc_select |=> (!o_wr throughout i_ack [->1])
    );

endmodule

`default_nettype wire

// File: verilog/rv_fetch_pc.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_config.svh"

module rv_fetch_pc
(
    input   wire                        i_clk,
    input   wire                        i_reset_n,
    input   wire                        i_pc_select,
    input   wire                        i_step,
    input   wire                        i_taken,
    input   wire rv_isa_pkg::word_t     i_pc_target,
    input   wire rv_isa_pkg::word_t     i_req_addr,
    input   wire rv_isa_pkg::word_t     i_pred_target,
    output  rv_isa_pkg::word_t          o_pc
);

    import rv_isa_pkg::*;

    word_t  pc_q;
    word_t  pc_seq;

    assign  pc_seq = i_req_addr + 32'd4;

    // Next request address, redirect first
    always_comb
    begin
        if (i_pc_select)
            o_pc = i_pc_target;
        else if (i_step)
            o_pc = i_taken ? i_pred_target : pc_seq;
        else
            o_pc = pc_q;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc_q <= `RV_RESET_ADDR;
        else
            pc_q <= o_pc;
    end

    // Covers redirect targets and predicted targets alike
    a_pc_aligned: assert property
    (
        @(posedge i_clk) disable iff (!i_reset_n)
        pc_q[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: verilog/rv_branch_predict.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_config.svh"

module rv_branch_predict
(
    input   wire rv_isa_pkg::word_t     i_instr,
    input   wire rv_isa_pkg::word_t     i_pc,
    output  logic                       o_taken,
    output  rv_isa_pkg::word_t          o_target
);

    import rv_isa_pkg::*;

    rv_opcode_t opcode;
    logic       is_word;
    logic       is_jal;
    logic       is_back_branch;
    word_t      j_offs;
    word_t      b_offs;

    assign  opcode = rv_opcode_t'(i_instr[6:2]);
    assign  is_word = (i_instr[1:0] == RV_OPC_LEN32);

    assign  is_jal = is_word && (opcode == OPC_JAL);
    // Loops close backwards, so negative offset means taken
    assign  is_back_branch = is_word && (opcode == OPC_BRANCH) && i_instr[31];

    // J-type immediate
    assign  j_offs = { {12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                       i_instr[30:21], 1'b0 };
    // B-type immediate
    assign  b_offs = { {20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                       i_instr[11:8], 1'b0 };

    assign  o_taken = `RV_FETCH_PREDICT && (is_jal || is_back_branch);
    assign  o_target = i_pc + (is_jal ? j_offs : b_offs);

endmodule

`default_nettype wire

// File: verilog/rv_fetch_buf.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_config.svh"

module rv_fetch_buf
(
    input   wire                        i_clk,
    input   wire                        i_reset_n,
    input   wire                        i_flush,
    input   wire                        i_wr,
    input   wire                        i_wr_pred,
    input   wire                        i_pop,
    input   wire rv_isa_pkg::word_t     i_wr_pc,
    input   wire rv_isa_pkg::word_t     i_wr_instr,
    output  logic                       o_has_room,
    output  logic                       o_valid,
    output  logic                       o_pred_taken,
    output  rv_isa_pkg::word_t          o_pc,
    output  rv_isa_pkg::word_t          o_instr
);

    import rv_isa_pkg::*;
    import rv_fetch_pkg::*;

    localparam int DEPTH = `RV_FETCH_BUF_DEPTH;
    localparam int CW = $clog2(DEPTH + 1);

    word_t          pc_mem      [DEPTH];
    word_t          instr_mem   [DEPTH];
    logic           pred_mem    [DEPTH];
    buf_idx_t       rd_ptr;
    buf_idx_t       wr_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  count_next;
    logic           pop;

    assign  pop = o_valid && i_pop;

    always_comb
    begin
        if (i_flush)
            count_next = '0;
        else
            count_next = count + CW'(i_wr) - CW'(pop);
    end

    // Looks one edge ahead so the controller can issue back to back
    assign  o_has_room = (count_next < CW'(DEPTH));

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_flush)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (i_wr)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_wr)
        begin
            pc_mem[wr_ptr] <= i_wr_pc;
            instr_mem[wr_ptr] <= i_wr_instr;
            pred_mem[wr_ptr] <= i_wr_pred;
        end
    end

    assign  o_valid = (count != '0);
    assign  o_pc = pc_mem[rd_ptr];
    assign  o_instr = instr_mem[rd_ptr];
    assign  o_pred_taken = pred_mem[rd_ptr];

    // Controller only issues with a slot reserved
    a_no_write_full: assert property
    (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_wr |-> (count < CW'(DEPTH))
    );

    // An underflow wraps the count past DEPTH
    a_no_underflow: assert property
    (
        @(posedge i_clk) disable iff (!i_reset_n)
        count <= CW'(DEPTH)
    );

    a_ptr_count: assert property
    (
        @(posedge i_clk) disable iff (!i_reset_n)
        buf_idx_t'(wr_ptr - rd_ptr) == buf_idx_t'(count)
    );

endmodule

`default_nettype wire

// File: verilog/rv_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_fetch_top
(
    input   wire                        i_clk,
    input   wire                        i_reset_n,
    input   wire                        i_pc_select,
    input   wire                        i_decode_ready,
    input   wire                        i_ack,
    input   wire rv_isa_pkg::word_t     i_pc_target,
    input   wire rv_isa_pkg::word_t     i_instruction,
    output  logic                       o_cyc,
    output  logic                       o_valid,
    output  logic                       o_pred_taken,
    output  rv_isa_pkg::word_t          o_addr,
    output  rv_isa_pkg::word_t          o_pc,
    output  rv_isa_pkg::word_t          o_instr
);

    import rv_isa_pkg::*;

    logic   wr;
    logic   has_room;
    logic   taken;
    word_t  fetch_pc;
    word_t  pred_target;

    rv_fetch_ctrl u_ctrl
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_pc_select        (i_pc_select),
        .i_ack              (i_ack),
        .i_has_room         (has_room),
        .i_fetch_pc         (fetch_pc),
        .o_cyc              (o_cyc),
        .o_wr               (wr),
        .o_addr             (o_addr)
    );

    rv_fetch_pc u_pc
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_pc_select        (i_pc_select),
        .i_step             (wr),
        .i_taken            (taken),
        .i_pc_target        (i_pc_target),
        .i_req_addr         (o_addr),
        .i_pred_target      (pred_target),
        .o_pc               (fetch_pc)
    );

    // Looks at the word on the bus, qualified by wr downstream
    rv_branch_predict u_predict
    (
        .i_instr            (i_instruction),
        .i_pc               (o_addr),
        .o_taken            (taken),
        .o_target           (pred_target)
    );

    rv_fetch_buf u_buf
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_flush            (i_pc_select),
        .i_wr               (wr),
        .i_wr_pred          (taken),
        .i_pop              (i_decode_ready),
        .i_wr_pc            (o_addr),
        .i_wr_instr         (i_instruction),
        .o_has_room         (has_room),
        .o_valid            (o_valid),
        .o_pred_taken       (o_pred_taken),
        .o_pc               (o_pc),
        .o_instr            (o_instr)
    );

endmodule

`default_nettype wire

// File: bench/rv_fetch_tests.svh
task automatic wait_entry(output word_t pc, output word_t instr, output logic pred);
    int cycles;
    begin
        cycles = 0;
        while (q_pc.size() == 0)
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > 200)
                fail_run("No instruction reached decode within 200 cycles");
        end
        pc = q_pc.pop_front();
        instr = q_instr.pop_front();
        pred = q_pred.pop_front();
    end
endtask

// Next address follows the predicted target when one is expected
task automatic expect_entry(input word_t pc);
    word_t got_pc;
    word_t got_instr;
    logic  got_pred;
    begin
        wait_entry(got_pc, got_instr, got_pred);
        check_word("o_pc", got_pc, pc);
        check_word("o_instr", got_instr, prog_word(pc));
        check_bit("o_pred_taken", got_pred, taken_tgt.exists(pc));
        exp_pc = taken_tgt.exists(pc) ? taken_tgt[pc] : pc + 32'd4;
    end
endtask

task automatic check_stream(input int n);
    begin
        repeat (n) expect_entry(exp_pc);
    end
endtask

task automatic redirect_to(input word_t target);
    begin
        @(posedge i_clk);
        i_pc_select <= 1'b1;
        i_pc_target <= target;
        @(posedge i_clk);
        i_pc_select <= 1'b0;
        q_pc.delete();      // Older entries are flushed
        q_instr.delete();
        q_pred.delete();
        exp_pc = target;
    end
endtask

task automatic test_reset_start();
    int cycles;
    begin
        repeat (2)
        begin
            @(negedge i_clk);
            check_bit("o_cyc", o_cyc, 1'b0);
            check_bit("o_valid", o_valid, 1'b0);
        end
        @(posedge i_clk);
        i_reset_n <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > 4)
                fail_run("No bus request after reset release");
        end
        while (!o_cyc);
        check_word("o_addr", o_addr, `RV_RESET_ADDR);
    end
endtask

task automatic test_sequential();
    begin
        @(posedge i_clk);
        i_decode_ready <= 1'b1;
        exp_pc = `RV_RESET_ADDR;
        check_stream(16);
    end
endtask

task automatic test_back_pressure();
    int idle;
    int cycles;
    begin
        @(posedge i_clk);
        i_decode_ready <= 1'b0;
        idle = 0;
        cycles = 0;
        while (idle < 8)
        begin
            @(negedge i_clk);
            cycles++;
            idle = (o_valid && !o_cyc) ? idle + 1 : 0;
            if (cycles > 200)
                fail_run("Queue never filled with decode stalled");
        end
        // Full queue, nothing lost on the way
        check_word("queued words", word_t'(ack_cnt - pop_cnt), word_t'(`RV_FETCH_BUF_DEPTH));
        @(posedge i_clk);
        i_decode_ready <= 1'b1;
        check_stream(`RV_FETCH_BUF_DEPTH + 4);
    end
endtask

task automatic test_redirect();
    int cycles;
    begin
        // Memory still owes the word two edges from now
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > 200)
                fail_run("No outstanding request seen before redirect");
        end
        while (!(o_cyc && !i_ack && wait_cnt > 0));
        redirect_to(32'h0000_0200);
        check_stream(6);
        // Acknowledge goes out on the next edge
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > 200)
                fail_run("No acknowledge to line up with a redirect");
        end
        while (!(o_cyc && !i_ack && wait_cnt == 0));
        redirect_to(32'h0000_0300);
        check_stream(6);
    end
endtask

task automatic test_prediction();
    begin
        // jal x1, +0x40
        prog[32'h400] = {1'b0, 10'h020, 1'b0, 8'h00, 5'd1, OPC_JAL, 2'b11};
        taken_tgt[32'h400] = 32'h440;
        // beq x1, x2, -0x30
        prog[32'h440] = {1'b1, 6'h3e, 5'd2, 5'd1, 3'b000, 4'h8, 1'b1, OPC_BRANCH, 2'b11};
        taken_tgt[32'h440] = 32'h410;
        // beq x1, x2, +0x20, not predicted
        prog[32'h410] = {1'b0, 6'h01, 5'd2, 5'd1, 3'b000, 4'h0, 1'b0, OPC_BRANCH, 2'b11};
        redirect_to(32'h0000_0400);
        expect_entry(32'h400);
        expect_entry(32'h440);
        expect_entry(32'h410);
        expect_entry(32'h414);
        check_stream(8);
    end
endtask

// File: bench/rv_fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_config.svh"

module rv_fetch_tb;

    import rv_isa_pkg::*;

    logic   i_clk;
    logic   i_reset_n;
    logic   i_pc_select;
    logic   i_decode_ready;
    logic   i_ack;
    word_t  i_pc_target;
    word_t  i_instruction;
    logic   o_cyc;
    logic   o_valid;
    logic   o_pred_taken;
    word_t  o_addr;
    word_t  o_pc;
    word_t  o_instr;

    word_t  prog [word_t];          // Sparse program, default word elsewhere
    word_t  taken_tgt [word_t];     // Expected predicted target per address
    word_t  q_pc [$];
    word_t  q_instr [$];
    logic   q_pred [$];
    word_t  exp_pc;
    int unsigned lcg_state = 68;
    int     wait_cnt = -1;
    int     ack_cnt = 0;            // Acknowledges seen by the DUT
    int     pop_cnt = 0;            // Entries taken by decode
    logic   cyc_s;
    word_t  addr_s;

    rv_fetch_top UUT
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_pc_select    (i_pc_select),
        .i_decode_ready (i_decode_ready),
        .i_ack          (i_ack),
        .i_pc_target    (i_pc_target),
        .i_instruction  (i_instruction),
        .o_cyc          (o_cyc),
        .o_valid        (o_valid),
        .o_pred_taken   (o_pred_taken),
        .o_addr         (o_addr),
        .o_pc           (o_pc),
        .o_instr        (o_instr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic fail_run(input string msg);
        begin
            $display("%s", msg);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        begin
            if (got !== exp)
            begin
                $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
                fail_run("Word compare mismatch");
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        begin
            if (got !== exp)
            begin
                $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
                fail_run("Bit compare mismatch");
            end
        end
    endtask

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // OP-IMM word with its fields folded from the whole address
    function automatic word_t prog_word(input word_t addr);
        if (prog.exists(addr))
            return prog[addr];
        return {addr[13:2] ^ addr[25:14], addr[30:26], addr[31], addr[1:0], 5'd1,
                OPC_OP_IMM, 2'b11};
    endfunction

    // Memory model, answers after 0 to 3 wait cycles
    always @(negedge i_clk)
    begin
        cyc_s <= o_cyc;
        addr_s <= o_addr;
    end

    always @(posedge i_clk)
    begin
        if (!i_reset_n || i_ack)
        begin
            if (i_ack)
                ack_cnt++;
            i_ack <= 1'b0;
            wait_cnt = -1;
        end
        else if (cyc_s)
        begin
            if (wait_cnt < 0)
                wait_cnt = lcg_next() % 4;
            if (wait_cnt == 0)
            begin
                i_ack <= 1'b1;
                i_instruction <= prog_word(addr_s);
                wait_cnt = -1;
            end
            else
                wait_cnt = wait_cnt - 1;
        end
    end

    // Entries consumed at the coming edge
    always @(negedge i_clk)
    begin
        if (i_reset_n && o_valid && i_decode_ready)
        begin
            q_pc.push_back(o_pc);
            q_instr.push_back(o_instr);
            q_pred.push_back(o_pred_taken);
            pop_cnt++;
        end
    end

    initial
    begin
        repeat (4000) @(posedge i_clk);
        fail_run("Watchdog expired, the tests did not finish in 4000 cycles");
    end

    `include "rv_fetch_tests.svh"

    initial
    begin
        i_reset_n = 1'b0;
        i_pc_select = 1'b0;
        i_decode_ready = 1'b0;
        i_ack = 1'b0;
        i_pc_target = '0;
        i_instruction = '0;
        cyc_s = 1'b0;
        addr_s = '0;
        test_reset_start();
        test_sequential();
        test_back_pressure();
        test_redirect();
        test_prediction();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_fetch_top.f
+incdir+verilog
+incdir+bench
verilog/rv_isa_pkg.sv
verilog/rv_fetch_pkg.sv
verilog/rv_fetch_ctrl.sv
verilog/rv_fetch_pc.sv
verilog/rv_branch_predict.sv
verilog/rv_fetch_buf.sv
verilog/rv_fetch_top.sv
bench/rv_fetch_tb.sv
